// ==== sim.f ====
cdc_pkg.sv
dual_port_ram.sv
gray_ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the async FIFO testbench with Verilator.
# The run fails if any step fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_async_fifo

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module "$TOP" -Mdir "$OBJ" -o vsim
if [ $? -ne 0 ]; then
  echo "run.sh: compile failed"
  exit 1
fi

"./$OBJ/vsim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "run.sh: FAIL"
  exit 1
fi

echo "run.sh: PASS"
exit 0

// ==== tb_async_fifo.sv ====
`timescale 1ns/1ps

module tb_async_fifo;

  localparam int DATA_WIDTH = 8;
  localparam int DEPTH = 16;
  localparam int AFULL = 12;
  localparam int AEMPTY = 2;
  localparam real WR_HALF = 5.5; // 11 ns write clock
  localparam real RD_HALF = 4.0; // 8 ns read clock
  localparam int SEED = 32'h7df5_b819;
  localparam int RAND_CYCLES = 2000;
  localparam int PHASE_CYCLES = 3000; // reset, fill, drain, random, final drain
  localparam int TIMEOUT_CYCLES = 2 * PHASE_CYCLES;

  localparam int PH_RESET = 0;
  localparam int PH_FILL = 1;
  localparam int PH_DRAIN = 2;
  localparam int PH_RANDOM = 3;
  localparam int PH_FINAL = 4;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_valid;
  cdc_pkg::wr_status_t   wr_status;
  cdc_pkg::rd_status_t   rd_status;

  logic [DATA_WIDTH-1:0] model_q[$];
  int                    model_cnt = 0;
  logic [DATA_WIDTH-1:0] model_head = '0;
  int                    wr_idle = 0;
  int                    rd_idle = 0;
  int                    phase = PH_RESET;
  int                    err_cnt = 0;
  int                    rd_words = 0;
  int                    cycle_cnt = 0;
  logic                  rand_done = 1'b0;
  logic                  quiet;
  logic                  in_reset;

  assign quiet    = (wr_idle >= 8) && (rd_idle >= 8);
  assign in_reset = !wr_rst_n || !rd_rst_n;

  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (DEPTH),
    .FIFO_AFULL  (AFULL),
    .FIFO_AEMPTY (AEMPTY)
  ) u_dut (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .wr_status (wr_status),
    .rd_status (rd_status)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_HALF) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_HALF) rd_clk = ~rd_clk;
  end

  // reference queue, pushed on accepted writes
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !wr_status.full) begin
      model_q.push_back(wr_data);
      model_cnt  <= model_q.size();
      model_head <= model_q[0];
    end
    wr_idle <= wr_en ? 0 : wr_idle + 1;
  end

  // popped on every word the DUT hands out
  always @(posedge rd_clk) begin
    if (rd_rst_n && rd_valid && model_q.size() > 0) begin
      void'(model_q.pop_front());
      model_cnt  <= model_q.size();
      model_head <= (model_q.size() > 0) ? model_q[0] : '0;
      rd_words   <= rd_words + 1;
    end
    rd_idle <= rd_en ? 0 : rd_idle + 1;
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    err_cnt++;
    $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
  endtask

  task automatic note_failure(input string what);
    err_cnt++;
    $display("%s", what);
  endtask

  a_reset_state : assert property (@(posedge rd_clk)
    (phase == PH_RESET && !in_reset) |-> ({rd_status, wr_status, rd_valid} == 5'b11000))
    else report_mismatch("reset_state", 5'b11000, int'($sampled({rd_status, wr_status, rd_valid})));

  a_read_order : assert property (@(posedge rd_clk) disable iff (in_reset)
    rd_valid |-> model_cnt > 0)
    else note_failure("read_order: rd_valid while the model queue is empty");

  a_read_data : assert property (@(posedge rd_clk) disable iff (in_reset)
    (rd_valid && model_cnt > 0) |-> rd_data == model_head)
    else report_mismatch("read_data", int'($sampled(model_head)), int'($sampled(rd_data)));

  a_full_early : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (phase == PH_FILL && wr_status.full) |-> model_cnt == DEPTH)
    else report_mismatch("full_early", DEPTH, $sampled(model_cnt));

  a_fill_overflow : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (phase == PH_FILL) |-> model_cnt <= DEPTH)
    else note_failure("fill_overflow: more words accepted than the FIFO holds");

  a_full_hold : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (phase == PH_FILL && wr_en && wr_status.full) |=> wr_status.full)
    else report_mismatch("full_hold", 1, int'($sampled(wr_status.full)));

  a_wr_flags_quiet : assert property (@(posedge wr_clk) disable iff (in_reset)
    quiet |-> wr_status == {model_cnt == DEPTH, model_cnt >= AFULL})
    else report_mismatch("wr_flags_quiet",
      int'($sampled({model_cnt == DEPTH, model_cnt >= AFULL})), int'($sampled(wr_status)));

  a_rd_flags_quiet : assert property (@(posedge rd_clk) disable iff (in_reset)
    quiet |-> rd_status == {model_cnt == 0, model_cnt <= AEMPTY})
    else report_mismatch("rd_flags_quiet",
      int'($sampled({model_cnt == 0, model_cnt <= AEMPTY})), int'($sampled(rd_status)));

  a_empty_early : assert property (@(posedge rd_clk) disable iff (in_reset)
    !rd_status.empty |-> model_cnt > 0)
    else note_failure("empty_early: empty is low while the model holds no words");

  a_read_while_empty : assert property (@(posedge rd_clk) disable iff (in_reset)
    (rd_en && rd_status.empty) |=> !rd_valid)
    else note_failure("read_while_empty: rd_valid after a read of an empty FIFO");

  a_final_drain : assert property (@(posedge rd_clk) disable iff (in_reset)
    (phase == PH_FINAL && quiet) |-> model_cnt == 0)
    else report_mismatch("final_drain", 0, $sampled(model_cnt));

  task automatic write_burst(input int n);
    repeat (n) begin
      @(negedge wr_clk);
      wr_en   = 1'b1;
      wr_data = DATA_WIDTH'($urandom);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_burst(input int n);
    repeat (n) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  // both sides idle, flags given time to be checked
  task automatic settle();
    wait (quiet);
    repeat (6) @(negedge rd_clk);
  endtask

  task automatic drive_random_reads();
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(negedge rd_clk);
      rd_en = ($urandom % 100) < ((i < RAND_CYCLES / 2) ? 30 : 70); // fill, then drain
    end
    rand_done = 1'b1;
  endtask

  task automatic drive_random_writes();
    while (!rand_done) begin
      @(negedge wr_clk);
      wr_en   = ($urandom % 100) < 60;
      wr_data = DATA_WIDTH'($urandom);
    end
    wr_en = 1'b0;
  endtask

  task automatic drain_all();
    int empty_run;
    empty_run = 0;
    @(negedge rd_clk);
    rd_en = 1'b1;
    while (empty_run < 8) begin
      @(negedge rd_clk);
      empty_run = rd_status.empty ? empty_run + 1 : 0;
    end
    rd_en = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    fork
      begin
        repeat (3) @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (3) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join
    repeat (10) @(negedge rd_clk);
    phase = PH_FILL; // read side idle
    write_burst(5);
    settle();
    write_burst(5);
    settle();
    write_burst(3); // past almost-full
    settle();
    write_burst(6); // three land on a full FIFO
    settle();
    phase = PH_DRAIN;
    read_burst(5);
    settle();
    read_burst(10);
    settle();
    read_burst(4); // three land on an empty FIFO
    settle();
    phase = PH_RANDOM;
    fork
      drive_random_reads();
      drive_random_writes();
    join
    phase = PH_FINAL;
    drain_all();
    settle();
    $display("summary: %0d errors, %0d words read, %0d read cycles", err_cnt, rd_words,
             cycle_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d read clock cycles", TIMEOUT_CYCLES);
    $display("summary: %0d errors, %0d words read", err_cnt, rd_words);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = cdc_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = cdc_pkg::DEF_FIFO_DEPTH, // power of two
  parameter int FIFO_AFULL  = FIFO_DEPTH - 1,
  parameter int FIFO_AEMPTY = 1
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_valid,
  output cdc_pkg::wr_status_t   wr_status,
  output cdc_pkg::rd_status_t   rd_status
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  ram_we;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_raddr;
  logic [ADDR_WIDTH:0]   wr_gray; // crosses to rd_clk
  logic [ADDR_WIDTH:0]   rd_gray; // crosses to wr_clk
  logic [ADDR_WIDTH:0]   wr_ptr_rsync;
  logic [ADDR_WIDTH:0]   rd_ptr_wsync;

  fifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_ptr_wsync (rd_ptr_wsync),
    .ram_we       (ram_we),
    .ram_waddr    (ram_waddr),
    .wr_gray      (wr_gray),
    .wr_status    (wr_status)
  );

  gray_ptr_sync #(.PTR_WIDTH(ADDR_WIDTH + 1)) u_wr2rd (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

  gray_ptr_sync #(.PTR_WIDTH(ADDR_WIDTH + 1)) u_rd2wr (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  fifo_rd_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_rsync (wr_ptr_rsync),
    .ram_re       (ram_re),
    .ram_raddr    (ram_raddr),
    .rd_gray      (rd_gray),
    .rd_valid     (rd_valid),
    .rd_status    (rd_status)
  );

  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (ram_we),
    .wr_addr  (ram_waddr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_re),
    .rd_addr  (ram_raddr),
    .rd_data  (rd_data)
  );

endmodule

// ==== fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module fifo_rd_ctrl #(
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AEMPTY = 1
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_ptr_rsync,
  output logic                  ram_re,
  output logic [ADDR_WIDTH-1:0] ram_raddr,
  output logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  rd_valid,
  output cdc_pkg::rd_status_t   rd_status
);

  localparam logic [ADDR_WIDTH:0] PTR_AEMPTY = (ADDR_WIDTH + 1)'(FIFO_AEMPTY);

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_nxt;
  logic [ADDR_WIDTH:0] rd_left_nxt;

  assign ram_re    = rd_en && !rd_status.empty; // reads while empty are dropped
  assign ram_raddr = rd_ptr[ADDR_WIDTH-1:0];

  assign rd_ptr_nxt  = rd_ptr + (ADDR_WIDTH + 1)'(ram_re);
  assign rd_left_nxt = wr_ptr_rsync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr   <= '0;
      rd_gray  <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_ptr   <= rd_ptr_nxt;
      rd_gray  <= (ADDR_WIDTH + 1)'(cdc_pkg::bin2gray(cdc_pkg::ptr_word_t'(rd_ptr_nxt)));
      rd_valid <= ram_re; // ram output loads on the same edge
    end
  end

  // write pointer lags, so flags err on the empty side
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status.empty  <= (rd_ptr_nxt == wr_ptr_rsync);
      rd_status.aempty <= (rd_left_nxt <= PTR_AEMPTY);
    end
  end

  // synced write pointer only moves ahead, so an accepted read never meets it
  a_no_underrun : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) ram_re |-> rd_ptr != wr_ptr_rsync
  ) else $error("fifo_rd_ctrl: read accepted at pointer %0d with no word", rd_ptr);

endmodule

// ==== fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module fifo_wr_ctrl #(
  parameter  int FIFO_DEPTH = 16,
  parameter  int FIFO_AFULL = FIFO_DEPTH - 1,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_ptr_wsync,
  output logic                  ram_we,
  output logic [ADDR_WIDTH-1:0] ram_waddr,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output cdc_pkg::wr_status_t   wr_status
);

  localparam logic [ADDR_WIDTH:0] PTR_DEPTH = (ADDR_WIDTH + 1)'(FIFO_DEPTH);
  localparam logic [ADDR_WIDTH:0] PTR_AFULL = (ADDR_WIDTH + 1)'(FIFO_AFULL);

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_nxt;
  logic [ADDR_WIDTH:0] wr_used;
  logic [ADDR_WIDTH:0] wr_used_nxt;

  assign ram_we    = wr_en && !wr_status.full; // writes while full are dropped
  assign ram_waddr = wr_ptr[ADDR_WIDTH-1:0];

  assign wr_ptr_nxt  = wr_ptr + (ADDR_WIDTH + 1)'(ram_we);
  assign wr_used     = wr_ptr - rd_ptr_wsync;
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_wsync; // modulo pointer width

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= (ADDR_WIDTH + 1)'(cdc_pkg::bin2gray(cdc_pkg::ptr_word_t'(wr_ptr_nxt)));
    end
  end

  // read pointer lags, so flags err on the full side
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status.full  <= (wr_used_nxt == PTR_DEPTH);
      wr_status.afull <= (wr_used_nxt >= PTR_AFULL);
    end
  end

  // stale read pointer can only make the gap look larger, never past depth
  a_no_overrun : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) wr_used <= PTR_DEPTH
  ) else $error("fifo_wr_ctrl: write pointer ahead by %0d", wr_used);

endmodule

// ==== gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int PTR_WIDTH = 5
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [PTR_WIDTH-1:0] gray_in,
  output logic [PTR_WIDTH-1:0] bin_out
);

  logic [PTR_WIDTH-1:0] sync_q1; // may go metastable
  logic [PTR_WIDTH-1:0] sync_q2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // each binary bit is the xor of all gray bits at or above it
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

// ==== dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // output register, loaded only on an accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // address comes from the write controller
  a_waddr_known : assert property (
    @(posedge wr_clk) wr_en |-> !$isunknown(wr_addr)
  ) else $error("dual_port_ram: write with unknown address %h", wr_addr);

endmodule

// ==== cdc_pkg.sv ====
package cdc_pkg;

  localparam int DEF_DATA_WIDTH = 8;
  localparam int DEF_FIFO_DEPTH = 16;

  // write domain flags
  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  // read domain flags
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  // pointers up to 32 bits, callers zero extend and truncate back
  typedef logic [31:0] ptr_word_t;

  // gray code of a binary pointer
  function automatic ptr_word_t bin2gray(input ptr_word_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage
